//--- list.f
rv_isa_pkg.sv
core_ctrl_pkg.sv
fetch_unit.sv
decode_unit.sv
reg_file.sv
alu.sv
exec_unit.sv
core_top.sv
core_props.sv
tb_checker.sv
tb_top.sv

//--- tb_top.sv
// core testbench
// clock, reset, instruction memory and fetch responder

module tb_top import rv_isa_pkg::*; ();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int mem_words     = 256;
    localparam int num_retires   = 300;
    localparam int max_ack_delay = 4;
    localparam int max_cycles    = num_retires * (max_ack_delay + 3) + 50;

    localparam logic [6:0] opc_load   = 7'b0000011;
    localparam logic [6:0] opc_store  = 7'b0100011;
    localparam logic [6:0] opc_system = 7'b1110011;

    logic     clk;
    logic     reset;
    logic     imem_req;
    logic     imem_ack;
    logic     retire_valid;
    logic     illegal;
    logic     rd_we;
    logic     report;
    word_t    imem_addr;
    word_t    imem_data;
    word_t    retire_pc;
    word_t    rd_data;
    reg_idx_t rd_addr;
    int       retires;
    int       errors;
    int       cycles = 0;
    integer   seed = 29;
    word_t    imem [mem_words];
    // kinds 0..8 are r, imm, lui, auipc, branch, jal, jalr, illegal and x0 write
    int       kind_of_draw [16] = '{0, 0, 0, 0, 1, 1, 1, 2, 3, 4, 4, 5, 6, 7, 8, 8};

    core_top #(.reset_pc(32'h0)) i_dut (.*);

    tb_checker #(.start_pc(32'h0)) i_checker (.*);

    always #4 clk = ~clk;

    // forward offsets only so control flow sweeps the whole memory
    function automatic word_t make_inst(input int kind, input word_t r);
        logic [2:0]  f3;
        logic [2:0]  bf3;
        logic [12:0] boff;
        logic [20:0] joff;
        logic [11:0] imm12;
        word_t       w;
        f3   = r[14:12];
        boff = {7'b0, r[27:24], 2'b00} + 13'd4;
        joff = {15'b0, r[27:24], 2'b00} + 21'd4;
        case (kind)
            0: w = {1'b0, (f3 == f3_add || f3 == f3_srl) ? r[30] : 1'b0, 5'b0,
                    r[24:20], r[19:15], f3, r[11:7], opc_op};
            1: begin
                if (f3 == f3_sll) imm12 = {7'b0, r[24:20]};
                else if (f3 == f3_srl) imm12 = {1'b0, r[30], 5'b0, r[24:20]};
                else imm12 = r[31:20];
                w = {imm12, r[19:15], f3, r[11:7], opc_op_imm};
            end
            2: w = {r[31:12], r[11:7], opc_lui};
            3: w = {r[31:12], r[11:7], opc_auipc};
            4: begin
                case (r[30:28] % 3'd6)
                    3'd0: bf3 = f3_beq;
                    3'd1: bf3 = f3_bne;
                    3'd2: bf3 = f3_blt;
                    3'd3: bf3 = f3_bge;
                    3'd4: bf3 = f3_bltu;
                    default: bf3 = f3_bgeu;
                endcase
                w = {boff[12], boff[10:5], r[24:20], r[19:15], bf3, boff[4:1], boff[11],
                     opc_branch};
            end
            5: w = {joff[20], joff[10:1], joff[11], joff[19:12], r[11:7], opc_jal};
            // x0 base and sometimes an odd offset
            6: w = {2'b00, r[29:22], 1'b0, r[21], 5'd0, 3'b000, r[11:7], opc_jalr};
            7: begin
                if (r[1:0] == 2'd0) w = {r[31:7], opc_load};
                else if (r[1:0] == 2'd1) w = {r[31:7], opc_store};
                else w = {r[31:7], opc_system};
            end
            default: begin
                if (r[0]) w = {7'b0, r[24:20], r[19:15], 3'b000, 5'd0, opc_op};
                else w = {r[31:20], r[19:15], 3'b000, 5'd0, opc_op_imm};
            end
        endcase
        return w;
    endfunction

    // fetch responder answers 1 to 4 cycles after each request
    always begin : ack_driver
        int delay;
        @(negedge clk);
        if (!reset && imem_req) begin
            delay = 1 + ($unsigned($random(seed)) % max_ack_delay);
            repeat (delay) @(negedge clk);
            imem_ack  = 1'b1;
            imem_data = imem[imem_addr[9:2]];  // word address modulo 256
            @(negedge clk);
            imem_ack  = 1'b0;
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= max_cycles) begin
            $display("timeout: %0d of %0d instructions retired after %0d cycles",
                     retires, num_retires, cycles);
            $display("Verification failed");
            $finish;
        end
    end

    initial begin : main
        word_t r;
        int    draw;
        clk       = 1'b0;
        reset     = 1'b1;
        imem_ack  = 1'b0;
        imem_data = '0;
        report    = 1'b0;
        for (int a = 0; a < mem_words; a++) begin
            draw    = $unsigned($random(seed)) % 16;
            r       = $random(seed);
            imem[a] = make_inst(kind_of_draw[draw], r);
        end
        repeat (10) @(negedge clk);
        reset = 1'b0;
        wait (retires >= num_retires);
        @(negedge clk);
        report = 1'b1;  // checker prints its per-test lines here
        @(posedge clk);
        $display("summary: %0d retired, %0d checker errors, %0d assertion failures",
                 retires, errors, i_dut.i_props.assert_errors);
        if (errors == 0 && i_dut.i_props.assert_errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

//--- tb_checker.sv
// reference model and retire comparator

module tb_checker import rv_isa_pkg::*; #(
    parameter word_t start_pc = '0
) (
    input  logic     clk,
    input  logic     reset,
    input  logic     imem_req,
    input  word_t    imem_addr,
    input  logic     imem_ack,
    input  word_t    imem_data,
    input  logic     retire_valid,
    input  word_t    retire_pc,
    input  logic     illegal,
    input  logic     rd_we,
    input  reg_idx_t rd_addr,
    input  word_t    rd_data,
    input  logic     report,
    output int       retires,
    output int       errors
);
    timeunit 1ns;
    timeprecision 1ps;

    word_t ref_regs [32] = '{default: '0};
    word_t ref_pc = start_pc;
    word_t cur_inst;
    logic  inst_held = 1'b0;
    int    acks = 0;
    int    fails = 0;
    int    summary_fails = 0;
    int    retire_misses;
    int    kind_checked [5] = '{default: 0};
    int    kind_failed [5] = '{default: 0};
    string kind_names [5] = '{"r-type alu", "immediate alu, lui, auipc", "branches",
                              "jal and jalr", "x0 writes and illegal opcodes"};

    assign errors = fails + summary_fails;

    function automatic word_t alu_ref(input logic [2:0] f3, input logic alt,
                                      input word_t a, input word_t b);
        logic [4:0] sh;
        sh = b[4:0];
        case (f3)
            f3_add:  if (alt) return a - b; else return a + b;
            f3_sll:  return a << sh;
            f3_slt:  return {31'b0, $signed(a) < $signed(b)};
            f3_sltu: return {31'b0, a < b};
            f3_xor:  return a ^ b;
            f3_srl:  if (alt) return $signed(a) >>> sh; else return a >> sh;
            f3_or:   return a | b;
            default: return a & b;
        endcase
    endfunction

    // next pc, write enable and write value of one instruction
    function automatic void predict(input word_t inst, input word_t pc, output word_t npc,
                                    output logic we, output word_t val, output logic bad);
        logic [2:0] f3;
        logic       take;
        word_t      a;
        word_t      b;
        word_t      imm_i;
        f3    = inst[14:12];
        a     = ref_regs[inst[19:15]];
        b     = ref_regs[inst[24:20]];
        imm_i = {{20{inst[31]}}, inst[31:20]};
        npc   = pc + 32'd4;
        we    = 1'b1;
        val   = '0;
        bad   = 1'b0;
        take  = 1'b0;
        case (inst[6:0])
            opc_op:     val = alu_ref(f3, inst[30], a, b);
            opc_op_imm: val = alu_ref(f3, f3 == f3_srl && inst[30], a, imm_i);
            opc_lui:    val = {inst[31:12], 12'h000};
            opc_auipc:  val = pc + {inst[31:12], 12'h000};
            opc_jal: begin
                val = pc + 32'd4;
                npc = pc + {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
            end
            opc_jalr: begin
                val = pc + 32'd4;
                npc = (a + imm_i) & ~32'd1;
            end
            opc_branch: begin
                we = 1'b0;
                case (f3)
                    f3_beq:  take = (a == b);
                    f3_bne:  take = (a != b);
                    f3_blt:  take = $signed(a) < $signed(b);
                    f3_bge:  take = $signed(a) >= $signed(b);
                    f3_bltu: take = a < b;
                    f3_bgeu: take = a >= b;
                    default: take = 1'b0;
                endcase
                if (take) npc = pc + {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
            end
            default: begin
                we  = 1'b0;
                bad = 1'b1;  // load, store, system and the rest
            end
        endcase
        if (inst[11:7] == 5'd0) we = 1'b0;
    endfunction

    task automatic check_value(input string what, input word_t got, input word_t exp);
        if (got !== exp) begin
            $display("Fail at %0t ns: %s is %h, expected %h", $time, what, got, exp);
            fails++;
            retire_misses++;
        end
    endtask

    always @(posedge clk) begin : compare
        word_t exp_npc;
        word_t exp_val;
        logic  exp_we;
        logic  exp_bad;
        int    kind;
        if (!reset) begin
            retire_misses = 0;
            if (imem_req) check_value("fetch address", imem_addr, ref_pc);
            if (imem_ack) begin
                if (inst_held) begin
                    $display("second fetch acknowledge at %0t ns before a retire", $time);
                    fails++;
                end
                cur_inst  = imem_data;
                inst_held = 1'b1;
                acks++;
            end
            if (retire_valid) begin
                if (!inst_held) begin
                    $display("instruction retired at %0t ns with no fetch acknowledge", $time);
                    fails++;
                end
                predict(cur_inst, ref_pc, exp_npc, exp_we, exp_val, exp_bad);
                check_value("retire_pc", retire_pc, ref_pc);
                check_value("illegal", word_t'(illegal), word_t'(exp_bad));
                check_value("rd_we", word_t'(rd_we), word_t'(exp_we));
                if (exp_we) begin
                    check_value("rd_addr", word_t'(rd_addr), word_t'(cur_inst[11:7]));
                    check_value("rd_data", rd_data, exp_val);
                    ref_regs[cur_inst[11:7]] = exp_val;
                end
                case (cur_inst[6:0])
                    opc_op:            kind = 0;
                    opc_branch:        kind = 2;
                    opc_jal, opc_jalr: kind = 3;
                    default:           kind = 1;
                endcase
                if (exp_bad || (kind != 2 && cur_inst[11:7] == 5'd0)) kind = 4;
                kind_checked[kind]++;
                if (retire_misses > 0) kind_failed[kind]++;
                ref_pc    = exp_npc;
                inst_held = 1'b0;
                retires++;
            end
        end
    end

    // one line per test group at the end of the run
    always @(posedge report) begin
        for (int k = 0; k < 5; k++) begin
            if (kind_checked[k] == 0) begin
                $display("test %s: no instruction of this kind retired", kind_names[k]);
                summary_fails++;
            end else begin
                $display("test %s: %0d retired, %0d failed", kind_names[k],
                         kind_checked[k], kind_failed[k]);
            end
        end
        $display("test fetch handshake: %0d acknowledges, %0d retires", acks, retires);
        if (acks != retires) begin
            $display("acknowledge and retire counts differ");
            summary_fails++;
        end
    end

endmodule

//--- core_props.sv
// fetch and retire timing assertions

module core_props import rv_isa_pkg::*; (
    input logic     clk,
    input logic     reset,
    input logic     imem_req,
    input logic     imem_ack,
    input logic     retire_valid,
    input logic     rd_we,
    input reg_idx_t rd_addr
);
    timeunit 1ns;
    timeprecision 1ps;

    int assert_errors = 0;

    ack_then_retire: assert property (@(posedge clk) disable iff (reset)
        imem_ack |=> retire_valid)
        else begin assert_errors++; $error("retire did not follow the acknowledge"); end

    retire_after_ack: assert property (@(posedge clk) disable iff (reset)
        retire_valid |-> $past(imem_ack))
        else begin assert_errors++; $error("retire without an acknowledge before it"); end

    retire_then_req: assert property (@(posedge clk) disable iff (reset)
        retire_valid |=> imem_req)
        else begin assert_errors++; $error("no fetch request after retire"); end

    write_only_at_retire: assert property (@(posedge clk) disable iff (reset)
        rd_we |-> retire_valid && rd_addr != '0)
        else begin assert_errors++; $error("register write outside retire or to x0"); end

    // first edge still sees the power-up state
    quiet_in_reset: assert property (@(posedge clk)
        reset && $past(reset) |-> !imem_req && !retire_valid && !rd_we)
        else begin assert_errors++; $error("control output active during reset"); end

endmodule

bind core_top core_props i_props (
    .clk          (clk),
    .reset        (reset),
    .imem_req     (imem_req),
    .imem_ack     (imem_ack),
    .retire_valid (retire_valid),
    .rd_we        (rd_we),
    .rd_addr      (rd_addr)
);

//--- core_top.sv
// RV32I single-issue core
// top level

module core_top import rv_isa_pkg::*, core_ctrl_pkg::*; #(
    parameter word_t reset_pc = 32'h8000_0000
) (
    input  logic     clk,
    input  logic     reset,
    output logic     imem_req,
    output word_t    imem_addr,
    input  logic     imem_ack,
    input  word_t    imem_data,
    output logic     retire_valid,
    output word_t    retire_pc,
    output logic     illegal,
    output logic     rd_we,
    output reg_idx_t rd_addr,
    output word_t    rd_data
);

    word_t      next_pc;
    word_t      inst;
    logic [6:0] opcode;
    logic [2:0] funct3;
    reg_idx_t   rs1;
    reg_idx_t   rs2;
    word_t      imm;
    inst_fmt_t  fmt;
    alu_op_t    alu_op;
    word_t      rs1_data;
    word_t      rs2_data;

    // exec_valid and pc of the fetch unit are the retire outputs
    fetch_unit #(
        .reset_pc (reset_pc)
    ) i_fetch (
        .clk        (clk),
        .reset      (reset),
        .imem_ack   (imem_ack),
        .imem_data  (imem_data),
        .next_pc    (next_pc),
        .imem_req   (imem_req),
        .imem_addr  (imem_addr),
        .pc         (retire_pc),
        .inst       (inst),
        .exec_valid (retire_valid)
    );

    decode_unit i_decode (
        .inst    (inst),
        .opcode  (opcode),
        .funct3  (funct3),
        .rs1     (rs1),
        .rs2     (rs2),
        .rd      (rd_addr),
        .imm     (imm),
        .fmt     (fmt),
        .alu_op  (alu_op),
        .illegal (illegal)
    );

    reg_file i_regs (
        .clk    (clk),
        .reset  (reset),
        .we     (rd_we),
        .waddr  (rd_addr),
        .wdata  (rd_data),
        .raddr1 (rs1),
        .raddr2 (rs2),
        .rdata1 (rs1_data),
        .rdata2 (rs2_data)
    );

    exec_unit i_exec (
        .exec_valid (retire_valid),
        .pc         (retire_pc),
        .opcode     (opcode),
        .funct3     (funct3),
        .fmt        (fmt),
        .alu_op     (alu_op),
        .imm        (imm),
        .rd         (rd_addr),
        .illegal    (illegal),
        .rs1_data   (rs1_data),
        .rs2_data   (rs2_data),
        .next_pc    (next_pc),
        .rd_we      (rd_we),
        .rd_data    (rd_data)
    );

endmodule

//--- exec_unit.sv
// execute stage
// operands, branches, next pc and write-back

module exec_unit import rv_isa_pkg::*, core_ctrl_pkg::*; (
    input  logic       exec_valid,
    input  word_t      pc,
    input  logic [6:0] opcode,
    input  logic [2:0] funct3,
    input  inst_fmt_t  fmt,
    input  alu_op_t    alu_op,
    input  word_t      imm,
    input  reg_idx_t   rd,
    input  logic       illegal,
    input  word_t      rs1_data,
    input  word_t      rs2_data,
    output word_t      next_pc,
    output logic       rd_we,
    output word_t      rd_data
);

    word_t   alu_a;
    word_t   alu_b;
    word_t   alu_result;
    word_t   link_addr;
    logic    taken;
    logic    writes_back;
    wb_sel_t wb_sel;

    assign link_addr = pc + word_t'(4);

    // first operand
    always_comb begin
        case (opcode)
            opc_lui:                        alu_a = '0;
            opc_auipc, opc_jal, opc_branch: alu_a = pc;  // pc-relative
            default:                        alu_a = rs1_data;
        endcase
    end

    assign alu_b = (fmt == fmt_r) ? rs2_data : imm;

    alu i_alu (
        .a      (alu_a),
        .b      (alu_b),
        .op     (alu_op),
        .result (alu_result)
    );

    // branch condition, the alu is busy with the target
    always_comb begin
        case (funct3)
            f3_beq:  taken = (rs1_data == rs2_data);
            f3_bne:  taken = (rs1_data != rs2_data);
            f3_blt:  taken = ($signed(rs1_data) < $signed(rs2_data));
            f3_bge:  taken = ($signed(rs1_data) >= $signed(rs2_data));
            f3_bltu: taken = (rs1_data < rs2_data);
            f3_bgeu: taken = (rs1_data >= rs2_data);
            default: taken = 1'b0;  // reserved encodings fall through
        endcase
    end

    always_comb begin
        if (opcode == opc_jalr) begin
            next_pc = {alu_result[xlen-1:1], 1'b0};
        end else if (opcode == opc_jal || (opcode == opc_branch && taken)) begin
            next_pc = alu_result;
        end else begin
            next_pc = link_addr;  // includes illegal opcodes
        end
    end

    assign wb_sel  = (opcode == opc_jal || opcode == opc_jalr) ? wb_link : wb_alu;
    assign rd_data = (wb_sel == wb_link) ? link_addr : alu_result;

    // branches are the only legal kind without a destination
    assign writes_back = (fmt != fmt_b) && !illegal;
    assign rd_we       = exec_valid && writes_back && (rd != '0);

endmodule

//--- alu.sv
// integer alu

module alu import rv_isa_pkg::*, core_ctrl_pkg::*; (
    input  word_t   a,
    input  word_t   b,
    input  alu_op_t op,
    output word_t   result
);

    localparam int shamt_w = $clog2(xlen);

    logic [shamt_w-1:0] shamt;

    assign shamt = b[shamt_w-1:0];  // upper bits of b ignored

    always_comb begin
        case (op)
            alu_add:  result = a + b;
            alu_sub:  result = a - b;
            alu_sll:  result = a << shamt;
            alu_slt:  result = word_t'($signed(a) < $signed(b));
            alu_sltu: result = word_t'(a < b);
            alu_xor:  result = a ^ b;
            alu_srl:  result = a >> shamt;
            alu_sra:  result = word_t'($signed(a) >>> shamt);
            alu_or:   result = a | b;
            alu_and:  result = a & b;
            default:  result = '0;
        endcase
    end

endmodule

//--- reg_file.sv
// integer register file

module reg_file import rv_isa_pkg::*; (
    input  logic     clk,
    input  logic     reset,
    input  logic     we,
    input  reg_idx_t waddr,
    input  word_t    wdata,
    input  reg_idx_t raddr1,
    input  reg_idx_t raddr2,
    output word_t    rdata1,
    output word_t    rdata2
);

    localparam int num_regs = 2 ** reg_addr_w;

    word_t regs [num_regs];

    // x0 is never written, the write enable already excludes rd == 0
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < num_regs; i++) begin
                regs[i] <= '0;
            end
        end else if (we) begin
            regs[waddr] <= wdata;
        end
    end

    // asynchronous reads
    assign rdata1 = regs[raddr1];
    assign rdata2 = regs[raddr2];

endmodule

//--- decode_unit.sv
// instruction decode
// fields, format, immediate and alu op

module decode_unit import rv_isa_pkg::*, core_ctrl_pkg::*; (
    input  word_t     inst,
    output logic [6:0] opcode,
    output logic [2:0] funct3,
    output reg_idx_t  rs1,
    output reg_idx_t  rs2,
    output reg_idx_t  rd,
    output word_t     imm,
    output inst_fmt_t fmt,
    output alu_op_t   alu_op,
    output logic      illegal
);

    logic funct7_b5;  // selects sub / sra

    assign opcode    = inst[6:0];
    assign rd        = inst[11:7];
    assign funct3    = inst[14:12];
    assign rs1       = inst[19:15];
    assign rs2       = inst[24:20];
    assign funct7_b5 = inst[30];

    // load, store and system fall into fmt_none
    always_comb begin
        case (opcode)
            opc_op:               fmt = fmt_r;
            opc_op_imm, opc_jalr: fmt = fmt_i;
            opc_branch:           fmt = fmt_b;
            opc_lui, opc_auipc:   fmt = fmt_u;
            opc_jal:              fmt = fmt_j;
            default:              fmt = fmt_none;
        endcase
    end

    assign illegal = (fmt == fmt_none);

    always_comb begin
        case (fmt)
            fmt_i: imm = {{20{inst[31]}}, inst[31:20]};
            fmt_b: imm = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
            fmt_u: imm = {inst[31:12], 12'b0};
            fmt_j: imm = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
            default: imm = '0;  // r-type has no immediate
        endcase
    end

    // everything that is not op / op_imm uses the adder
    always_comb begin
        alu_op = alu_add;
        if (fmt == fmt_r || opcode == opc_op_imm) begin
            case (funct3)
                f3_add:  alu_op = (fmt == fmt_r && funct7_b5) ? alu_sub : alu_add;
                f3_sll:  alu_op = alu_sll;
                f3_slt:  alu_op = alu_slt;
                f3_sltu: alu_op = alu_sltu;
                f3_xor:  alu_op = alu_xor;
                f3_srl:  alu_op = funct7_b5 ? alu_sra : alu_srl;  // srai keeps bit 30 too
                f3_or:   alu_op = alu_or;
                f3_and:  alu_op = alu_and;
                default: alu_op = alu_add;
            endcase
        end
    end

endmodule

//--- fetch_unit.sv
// instruction fetch
// pc register and fetch sequencing

module fetch_unit import rv_isa_pkg::*; #(
    parameter word_t reset_pc = 32'h8000_0000
) (
    input  logic  clk,
    input  logic  reset,
    input  logic  imem_ack,
    input  word_t imem_data,
    input  word_t next_pc,
    output logic  imem_req,
    output word_t imem_addr,
    output word_t pc,
    output word_t inst,
    output logic  exec_valid
);

    typedef enum logic [1:0] {
        st_req,   // only entered from reset
        st_wait,  // request out, waiting for ack
        st_exec   // one cycle, instruction retires
    } fetch_state_t;

    fetch_state_t state;

    // the request pulse is registered so it lines up with entry into st_wait
    always_ff @(posedge clk) begin
        if (reset) begin
            state    <= st_req;
            imem_req <= 1'b0;
        end else begin
            imem_req <= 1'b0;
            case (state)
                st_req: begin
                    state    <= st_wait;
                    imem_req <= 1'b1;
                end
                st_wait: begin
                    if (imem_ack) state <= st_exec;  // late ack just stretches the wait
                end
                st_exec: begin
                    state    <= st_wait;
                    imem_req <= 1'b1;  // next fetch right after retire
                end
                default: state <= st_req;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (reset) pc <= reset_pc;
        else if (state == st_exec) pc <= next_pc;
    end

    // stray acks outside st_wait are dropped
    always_ff @(posedge clk) begin
        if (state == st_wait && imem_ack) inst <= imem_data;
    end

    assign imem_addr  = pc;  // stable for the whole wait
    assign exec_valid = (state == st_exec);

endmodule

//--- core_ctrl_pkg.sv
// core control encodings

package core_ctrl_pkg;

    // alu operation select
    typedef enum logic [3:0] {
        alu_add  = 4'd0,
        alu_sub  = 4'd1,
        alu_sll  = 4'd2,
        alu_slt  = 4'd3,
        alu_sltu = 4'd4,
        alu_xor  = 4'd5,
        alu_srl  = 4'd6,
        alu_sra  = 4'd7,
        alu_or   = 4'd8,
        alu_and  = 4'd9
    } alu_op_t;

    // source of the register write-back value
    typedef enum logic {
        wb_alu  = 1'b0,
        wb_link = 1'b1  // pc + 4 for jal / jalr
    } wb_sel_t;

endpackage

//--- rv_isa_pkg.sv
// RV32I instruction set definitions
// widths, opcodes, funct3 codes and instruction formats

package rv_isa_pkg;

    localparam int xlen       = 32;
    localparam int reg_addr_w = 5;

    typedef logic [xlen-1:0]       word_t;
    typedef logic [reg_addr_w-1:0] reg_idx_t;

    // major opcodes handled by the core, anything else is illegal
    localparam logic [6:0] opc_op     = 7'b0110011;
    localparam logic [6:0] opc_op_imm = 7'b0010011;
    localparam logic [6:0] opc_lui    = 7'b0110111;
    localparam logic [6:0] opc_auipc  = 7'b0010111;
    localparam logic [6:0] opc_jal    = 7'b1101111;
    localparam logic [6:0] opc_jalr   = 7'b1100111;
    localparam logic [6:0] opc_branch = 7'b1100011;

    // branch conditions
    localparam logic [2:0] f3_beq  = 3'b000;
    localparam logic [2:0] f3_bne  = 3'b001;
    localparam logic [2:0] f3_blt  = 3'b100;
    localparam logic [2:0] f3_bge  = 3'b101;
    localparam logic [2:0] f3_bltu = 3'b110;
    localparam logic [2:0] f3_bgeu = 3'b111;

    // alu functions, shared by op and op_imm
    localparam logic [2:0] f3_add  = 3'b000;  // also sub
    localparam logic [2:0] f3_sll  = 3'b001;
    localparam logic [2:0] f3_slt  = 3'b010;
    localparam logic [2:0] f3_sltu = 3'b011;
    localparam logic [2:0] f3_xor  = 3'b100;
    localparam logic [2:0] f3_srl  = 3'b101;  // also sra
    localparam logic [2:0] f3_or   = 3'b110;
    localparam logic [2:0] f3_and  = 3'b111;

    typedef enum logic [2:0] {
        fmt_r,
        fmt_i,
        fmt_s,
        fmt_b,
        fmt_u,
        fmt_j,
        fmt_none  // unsupported opcode
    } inst_fmt_t;

endpackage
